/* Bender.yml */
package:
  name: bbc_memctl

sources:
  - verilog/bbc_pkg.sv
  - verilog/address_decode.sv
  - verilog/system_latches.sv
  - verilog/display_address.sv
  - verilog/cpu_bus_mux.sv
  - verilog/bbc_memctl.sv
  - target: test
    files:
      - tests/bbc_memctl_assertions.sv
      - tests/bbc_memctl_tb.sv

/* sim.f */
verilog/bbc_pkg.sv
verilog/address_decode.sv
verilog/system_latches.sv
verilog/display_address.sv
verilog/cpu_bus_mux.sv
verilog/bbc_memctl.sv
tests/bbc_memctl_assertions.sv
tests/bbc_memctl_tb.sv

/* tests/bbc_memctl_assertions.sv */
`timescale 1ns/10ps

module bbc_memctl_assertions (
	input logic                   CLK48M_I,
	input logic                   reset_n,
	input logic                   model_i,
	input bbc_pkg::cpu_bus_t      cpu_bus_i,
	input bbc_pkg::mem_req_t      mem_o,
	input logic [bbc_pkg::DW-1:0] romsel_o
);

	// Failed assertions so far
	int fail_count = 0;

	// RAM is written only in the CPU half of the cycle
	we_in_cpu_half: assert property (@(posedge CLK48M_I) mem_o.we |-> cpu_bus_i.phi0)
		else begin
			fail_count++;
			$error("Memory write strobe high with phi0 low");
		end

	cpu_owns_adr: assert property (@(posedge CLK48M_I)
		cpu_bus_i.phi0 |-> (mem_o.adr == cpu_bus_i.addr))
		else begin
			fail_count++;
			$error("Memory address is not the CPU address during phi0");
		end

	// Model B romsel has no bit 7
	romsel_b7_low: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		!model_i |-> !romsel_o[7])
		else begin
			fail_count++;
			$error("ROMSEL bit 7 set on the Model B");
		end

endmodule

bind bbc_memctl bbc_memctl_assertions bbc_memctl_assertions_i (
	.CLK48M_I  (CLK48M_I),
	.reset_n   (reset_n),
	.model_i   (model_i),
	.cpu_bus_i (cpu_bus_i),
	.mem_o     (mem_o),
	.romsel_o  (romsel_o)
);

/* tests/bbc_memctl_tb.sv */
`timescale 1ns/10ps

module bbc_memctl_tb;

	import bbc_pkg::*;

	localparam int unsigned SEED           = 32'h6634ec45;
	localparam int          PHASE_CYCLES   = 1000;
	localparam int          RESET_CYCLES   = 4;
	localparam int          TIMEOUT_CYCLES = 2500;

	logic          CLK48M_I;
	logic          reset_n;
	logic          model_i;
	cpu_bus_t      cpu_bus;
	crtc_t         crtc;
	periph_rd_t    periph;
	logic [7:0]    sys_pb;
	logic [DW-1:0] mem_di;
	mem_req_t      mem;
	logic [DW-1:0] cpu_di;
	logic [DW-1:0] romsel;
	logic          shadow_ram;
	logic          shadow_vid;
	logic          acc_y;
	logic          irq_n;

	// Reference copies of the DUT registers
	logic [7:0] m_romsel;
	logic [7:0] m_acccon;
	logic       m_vdu_op;
	logic [7:0] m_ic32;

	int errors;
	int checks;
	int cycle_cnt;

	bbc_memctl bbc_memctl_i (
		.CLK48M_I     (CLK48M_I),
		.reset_n      (reset_n),
		.model_i      (model_i),
		.cpu_bus_i    (cpu_bus),
		.crtc_i       (crtc),
		.periph_i     (periph),
		.sys_pb_i     (sys_pb),
		.mem_di_i     (mem_di),
		.mem_o        (mem),
		.cpu_di_o     (cpu_di),
		.romsel_o     (romsel),
		.shadow_ram_o (shadow_ram),
		.shadow_vid_o (shadow_vid),
		.acc_y_o      (acc_y),
		.irq_n_o      (irq_n)
	);

	initial begin
		CLK48M_I = 1'b0;
		forever begin
			#50 CLK48M_I = ~CLK48M_I;
		end
	end

	// Addresses lean toward SHEILA, the latch registers and the shadow window
	function automatic logic [15:0] rand_addr();
		int unsigned pick;
		pick = $urandom % 10;
		case (pick)
			0, 1, 2: return {8'hFE, 8'($urandom)};
			3:       return 16'hFE30 + 16'($urandom % 8);
			4, 5:    return 16'h3000 + 16'($urandom % 16'h5000);
			6:       return 16'hC000 + 16'($urandom % 16'h2000);
			default: return 16'($urandom);
		endcase
	endfunction

	function automatic logic [14:0] exp_disp(input logic [13:0] ma, input logic [4:0] ra,
		input logic [1:0] offs);
		logic [3:0] wrap;
		logic [3:0] aa;
		case (offs)
			2'd0:    wrap = 4'd8;
			2'd1:    wrap = 4'd12;
			2'd2:    wrap = 4'd6;
			default: wrap = 4'd11;
		endcase
		aa = ma[12] ? ma[11:8] + wrap : ma[11:8];
		if (ma[13]) begin
			return {aa[3], 4'b1111, ma[9:0]};
		end
		return {aa, ma[7:0], ra[2:0]};
	endfunction

	function automatic logic [7:0] exp_rdata(input logic [15:0] a, input logic m);
		logic [7:0] pg;
		logic [7:0] of;
		pg = a[15:8];
		of = a[7:0];
		if (a < 16'hFC00 || pg == 8'hFF) return mem_di;
		if (pg != 8'hFE) return 8'h00;
		if (of < 8'h08) return periph.crtc;
		if (of < 8'h10) return 8'h02;
		if (m && of >= 8'h18 && of <= 8'h1F) return periph.adc;
		if (m && of >= 8'h30 && of <= 8'h33) return m_romsel;
		if (m && of >= 8'h34 && of <= 8'h37) return m_acccon;
		if (of >= 8'h40 && of <= 8'h5F) return periph.sys_via;
		if (of >= 8'h60 && of <= 8'h7F) return periph.user_via;
		if (of >= 8'h80 && of <= 8'h9F) return periph.fdc;
		if (!m && of >= 8'hC0 && of <= 8'hDF) return periph.adc;
		return 8'h00;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		errors++;
		$display("[FAIL] %s at cycle %0d: expected %h, actual %h", name, cycle_cnt, exp_v, act_v);
	endtask

	task automatic drive_random(input logic m, input logic rst);
		reset_n       = rst;
		model_i       = m;
		cpu_bus.addr  = rand_addr();
		cpu_bus.wdata = 8'($urandom);
		cpu_bus.r_nw  = 1'($urandom);
		cpu_bus.sync  = 1'($urandom);
		cpu_bus.clken = 1'($urandom);
		cpu_bus.phi0  = 1'($urandom);
		crtc          = 19'($urandom);
		periph        = {32'($urandom), 10'($urandom)};
		sys_pb        = 8'($urandom);
		mem_di        = 8'($urandom);
	endtask

	task automatic check_outputs();
		logic [15:0] e_adr;
		logic        e_shadow;
		e_adr = cpu_bus.phi0 ? cpu_bus.addr : {1'b0, exp_disp(crtc.ma, crtc.ra, m_ic32[5:4])};
		e_shadow = (cpu_bus.addr >= 16'h3000) && (cpu_bus.addr <= 16'h7FFF) &&
			(m_acccon[2] || (m_acccon[1] && m_vdu_op && !cpu_bus.sync));
		checks++;
		if (mem.adr !== e_adr) report_mismatch("mem_adr", e_adr, mem.adr);
		if (mem.we !== (reset_n && cpu_bus.phi0 && !cpu_bus.r_nw))
			report_mismatch("mem_we", reset_n && cpu_bus.phi0 && !cpu_bus.r_nw, mem.we);
		if (mem.dout !== cpu_bus.wdata) report_mismatch("mem_dout", cpu_bus.wdata, mem.dout);
		if (cpu_di !== exp_rdata(cpu_bus.addr, model_i))
			report_mismatch("cpu_di", exp_rdata(cpu_bus.addr, model_i), cpu_di);
		if (romsel !== m_romsel) report_mismatch("romsel", m_romsel, romsel);
		if (shadow_ram !== e_shadow) report_mismatch("shadow_ram", e_shadow, shadow_ram);
		if (shadow_vid !== m_acccon[0]) report_mismatch("shadow_vid", m_acccon[0], shadow_vid);
		if (acc_y !== m_acccon[3]) report_mismatch("acc_y", m_acccon[3], acc_y);
		if (irq_n !== !(periph.sys_via_irq || periph.user_via_irq || m_acccon[7]))
			report_mismatch("irq_n",
				!(periph.sys_via_irq || periph.user_via_irq || m_acccon[7]), irq_n);
	endtask

	// Apply the register rules for the coming clock edge
	task automatic update_model();
		if (!reset_n) begin
			m_romsel = '0;
			m_acccon = '0;
			m_vdu_op = 1'b0;
			m_ic32   = '0;
			return;
		end
		if (cpu_bus.clken && !cpu_bus.r_nw && cpu_bus.addr[15:2] == 14'h3F8C)
			m_romsel = model_i ? cpu_bus.wdata : {1'b0, cpu_bus.wdata[6:0]};
		if (cpu_bus.clken && !cpu_bus.r_nw && model_i && cpu_bus.addr[15:2] == 14'h3F8D)
			m_acccon = cpu_bus.wdata;
		if (cpu_bus.clken && cpu_bus.sync)
			m_vdu_op = (cpu_bus.addr[15:13] == 3'b110);
		m_ic32[sys_pb[2:0]] = sys_pb[3];
	endtask

	task automatic run_cycle(input logic m, input logic rst);
		@(posedge CLK48M_I);
		#5;
		drive_random(m, rst);
		#85;
		check_outputs();
		update_model();
	endtask

	task automatic run_phase(input logic m);
		repeat (RESET_CYCLES) run_cycle(m, 1'b0);
		repeat (PHASE_CYCLES) run_cycle(m, 1'b1);
	endtask

	initial begin
		errors   = 0;
		checks   = 0;
		m_romsel = '0;
		m_acccon = '0;
		m_vdu_op = 1'b0;
		m_ic32   = '0;
		reset_n  = 1'b0;
		model_i  = 1'b0;
		cpu_bus  = '0;
		crtc     = '0;
		periph   = '0;
		sys_pb   = '0;
		mem_di   = '0;
		void'($urandom(SEED));
		// Model B phase then Master phase, both from reset
		run_phase(1'b0);
		run_phase(1'b1);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			bbc_memctl_i.bbc_memctl_assertions_i.fail_count);
		if (errors == 0 && bbc_memctl_i.bbc_memctl_assertions_i.fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge CLK48M_I);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* verilog/address_decode.sv */
`timescale 1ns/10ps

module address_decode (
	input  logic [bbc_pkg::CPU_AW-1:0] cpu_addr_i,
	input  logic                       model_i,
	output bbc_pkg::sel_t              sel_o
);

	import bbc_pkg::*;

	logic [7:0] page;
	logic [7:0] ofs;
	logic       io_fred;
	logic       io_jim;
	logic       io_sheila;

	assign page = cpu_addr_i[CPU_AW-1 -: 8];
	assign ofs  = cpu_addr_i[7:0];

	assign io_fred   = (page == FRED_PAGE);
	assign io_jim    = (page == JIM_PAGE);
	assign io_sheila = (page == SHEILA_PAGE);

	always_comb begin
		sel_o = '0;

		// Main regions
		sel_o.ram = (cpu_addr_i <= RAM_TOP);
		sel_o.rom = (cpu_addr_i >= ROM_BASE) && (cpu_addr_i < MOS_BASE);
		// MOS has a hole at FC00-FEFF for the I/O pages
		sel_o.mos = (cpu_addr_i >= MOS_BASE) && !io_fred && !io_jim && !io_sheila;

		if (io_sheila) begin
			sel_o.crtc     = (ofs[7:3] == SH_CRTC[7:3]);
			sel_o.acia     = (ofs[7:3] == SH_ACIA[7:3]);
			sel_o.romsel   = (ofs[7:2] == SH_ROMSEL[7:2]);
			sel_o.sys_via  = (ofs[7:5] == SH_SYS_VIA[7:5]);
			sel_o.user_via = (ofs[7:5] == SH_USER_VIA[7:5]);
			sel_o.fdc      = (ofs[7:5] == SH_FDC[7:5]);

			// ADC moved down to FE18 on the Master
			if (model_i) begin
				sel_o.adc    = (ofs[7:3] == SH_ADC_M[7:3]);
				sel_o.acccon = (ofs[7:2] == SH_ACCCON[7:2]);
			end else begin
				sel_o.adc    = (ofs[7:5] == SH_ADC_B[7:5]);
			end
		end
	end

endmodule

/* verilog/bbc_memctl.sv */
`timescale 1ns/10ps

module bbc_memctl (
	input  logic                   CLK48M_I,
	input  logic                   reset_n,
	input  logic                   model_i,
	input  bbc_pkg::cpu_bus_t      cpu_bus_i,
	input  bbc_pkg::crtc_t         crtc_i,
	input  bbc_pkg::periph_rd_t    periph_i,
	input  logic [7:0]             sys_pb_i,
	input  logic [bbc_pkg::DW-1:0] mem_di_i,
	output bbc_pkg::mem_req_t      mem_o,
	output logic [bbc_pkg::DW-1:0] cpu_di_o,
	output logic [bbc_pkg::DW-1:0] romsel_o,
	output logic                   shadow_ram_o,
	output logic                   shadow_vid_o,
	output logic                   acc_y_o,
	output logic                   irq_n_o
);

	import bbc_pkg::*;

	sel_t          sel;
	acccon_t       acccon;
	logic [DW-1:0] romsel;
	logic          vdu_op;
	logic [1:0]    disp_addr_offs;
	disp_addr_u    disp_addr;

	address_decode address_decode_i (
		.cpu_addr_i (cpu_bus_i.addr),
		.model_i    (model_i),
		.sel_o      (sel)
	);

	system_latches system_latches_i (
		.CLK48M_I         (CLK48M_I),
		.reset_n          (reset_n),
		.cpu_bus_i        (cpu_bus_i),
		.sel_i            (sel),
		.model_i          (model_i),
		.sys_pb_i         (sys_pb_i),
		.romsel_o         (romsel),
		.acccon_o         (acccon),
		.vdu_op_o         (vdu_op),
		.disp_addr_offs_o (disp_addr_offs)
	);

	display_address display_address_i (
		.crtc_i           (crtc_i),
		.disp_addr_offs_i (disp_addr_offs),
		.disp_addr_o      (disp_addr)
	);

	cpu_bus_mux cpu_bus_mux_i (
		.reset_n      (reset_n),
		.cpu_bus_i    (cpu_bus_i),
		.sel_i        (sel),
		.model_i      (model_i),
		.periph_i     (periph_i),
		.mem_di_i     (mem_di_i),
		.romsel_i     (romsel),
		.acccon_i     (acccon),
		.vdu_op_i     (vdu_op),
		.disp_addr_i  (disp_addr),
		.mem_o        (mem_o),
		.cpu_di_o     (cpu_di_o),
		.shadow_ram_o (shadow_ram_o),
		.irq_n_o      (irq_n_o)
	);

	assign romsel_o     = romsel;
	// Display from shadow RAM
	assign shadow_vid_o = acccon.d;
	assign acc_y_o      = acccon.y;

endmodule

/* verilog/bbc_pkg.sv */
package bbc_pkg;

	// Bus widths
	localparam int CPU_AW  = 16;
	localparam int DW      = 8;
	localparam int DISP_AW = 15;
	localparam int MA_W    = 14;
	localparam int RA_W    = 5;

	// Memory regions
	localparam logic [CPU_AW-1:0] RAM_TOP  = 16'h7FFF;
	localparam logic [CPU_AW-1:0] ROM_BASE = 16'h8000;
	localparam logic [CPU_AW-1:0] MOS_BASE = 16'hC000;

	// I/O pages at the top of the MOS region
	localparam logic [7:0] FRED_PAGE   = 8'hFC;
	localparam logic [7:0] JIM_PAGE    = 8'hFD;
	localparam logic [7:0] SHEILA_PAGE = 8'hFE;

	// SHEILA device base offsets
	localparam logic [7:0] SH_CRTC     = 8'h00;
	localparam logic [7:0] SH_ACIA     = 8'h08;
	localparam logic [7:0] SH_ADC_M    = 8'h18;
	localparam logic [7:0] SH_ADC_B    = 8'hC0;
	localparam logic [7:0] SH_ROMSEL   = 8'h30;
	localparam logic [7:0] SH_ACCCON   = 8'h34;
	localparam logic [7:0] SH_SYS_VIA  = 8'h40;
	localparam logic [7:0] SH_USER_VIA = 8'h60;
	localparam logic [7:0] SH_FDC      = 8'h80;

	// ACIA is not fitted, status reads as TDRE only
	localparam logic [DW-1:0] ACIA_STATUS = 8'h02;

	// Master shadow window and VDU driver code page
	localparam logic [CPU_AW-1:0] SHADOW_LO = 16'h3000;
	localparam logic [CPU_AW-1:0] SHADOW_HI = 16'h7FFF;
	localparam logic [2:0]        VDU_PAGE  = 3'b110;

	// Hardware scroll wrap, entry 0 first (modes 3, 6, 0-2, 4-5)
	localparam logic [3:0][3:0] SCROLL_OFS = {4'd11, 4'd6, 4'd12, 4'd8};

	typedef struct packed {
		logic [CPU_AW-1:0] addr;
		logic [DW-1:0]     wdata;
		logic              r_nw;
		logic              sync;
		logic              clken;
		logic              phi0;
	} cpu_bus_t;

	typedef struct packed {
		logic [MA_W-1:0] ma;
		logic [RA_W-1:0] ra;
	} crtc_t;

	typedef struct packed {
		logic [DW-1:0] crtc;
		logic [DW-1:0] sys_via;
		logic [DW-1:0] user_via;
		logic [DW-1:0] adc;
		logic [DW-1:0] fdc;
		logic          sys_via_irq;
		logic          user_via_irq;
	} periph_rd_t;

	typedef struct packed {
		logic ram;
		logic rom;
		logic mos;
		logic crtc;
		logic acia;
		logic sys_via;
		logic user_via;
		logic adc;
		logic romsel;
		logic acccon;
		logic fdc;
	} sel_t;

	typedef struct packed {
		logic irr;
		logic tst;
		logic ifj;
		logic itu;
		logic y;
		logic x;
		logic e;
		logic d;
	} acccon_t;

	typedef struct packed {
		logic [CPU_AW-1:0] adr;
		logic              we;
		logic [DW-1:0]     dout;
	} mem_req_t;

	typedef struct packed {
		logic [3:0] aa;
		logic [7:0] ma_lo;
		logic [2:0] ra;
	} disp_hires_t;

	typedef struct packed {
		logic       aa3;
		logic [3:0] ones;
		logic [9:0] ma_lo;
	} disp_ttx_t;

	// Same screen address, bitmap or teletext layout
	typedef union packed {
		disp_hires_t hires;
		disp_ttx_t   ttx;
	} disp_addr_u;

endpackage

/* verilog/cpu_bus_mux.sv */
`timescale 1ns/10ps

module cpu_bus_mux (
	input  logic                   reset_n,
	input  bbc_pkg::cpu_bus_t      cpu_bus_i,
	input  bbc_pkg::sel_t          sel_i,
	input  logic                   model_i,
	input  bbc_pkg::periph_rd_t    periph_i,
	input  logic [bbc_pkg::DW-1:0] mem_di_i,
	input  logic [bbc_pkg::DW-1:0] romsel_i,
	input  bbc_pkg::acccon_t       acccon_i,
	input  logic                   vdu_op_i,
	input  bbc_pkg::disp_addr_u    disp_addr_i,
	output bbc_pkg::mem_req_t      mem_o,
	output logic [bbc_pkg::DW-1:0] cpu_di_o,
	output logic                   shadow_ram_o,
	output logic                   irq_n_o
);

	import bbc_pkg::*;

	logic in_window;

	// CPU read data, memory first then SHEILA devices
	always_comb begin
		if (sel_i.ram || sel_i.rom || sel_i.mos) begin
			cpu_di_o = mem_di_i;
		end else if (sel_i.crtc) begin
			cpu_di_o = periph_i.crtc;
		end else if (sel_i.acia) begin
			cpu_di_o = ACIA_STATUS;
		end else if (sel_i.sys_via) begin
			cpu_di_o = periph_i.sys_via;
		end else if (sel_i.user_via) begin
			cpu_di_o = periph_i.user_via;
		end else if (sel_i.adc) begin
			cpu_di_o = periph_i.adc;
		end else if (sel_i.acccon) begin
			cpu_di_o = acccon_i;
		end else if (sel_i.romsel && model_i) begin
			cpu_di_o = romsel_i;
		end else if (sel_i.fdc) begin
			cpu_di_o = periph_i.fdc;
		end else begin
			// Unmapped locations pull low
			cpu_di_o = '0;
		end
	end

	// Shadow RAM at 3000-7FFF, always with X or from VDU code with E
	assign in_window    = (cpu_bus_i.addr >= SHADOW_LO) && (cpu_bus_i.addr <= SHADOW_HI);
	assign shadow_ram_o = in_window &&
		(acccon_i.x || (acccon_i.e && vdu_op_i && !cpu_bus_i.sync));

	assign irq_n_o = ~(periph_i.sys_via_irq | periph_i.user_via_irq | acccon_i.irr);

	// CPU owns RAM in phi0 high, video fetches in the other half
	always_comb begin
		if (cpu_bus_i.phi0) begin
			mem_o.adr = cpu_bus_i.addr;
		end else begin
			mem_o.adr = {{(CPU_AW-DISP_AW){1'b0}}, disp_addr_i};
		end
		mem_o.we   = reset_n && cpu_bus_i.phi0 && !cpu_bus_i.r_nw;
		mem_o.dout = cpu_bus_i.wdata;
	end

endmodule

/* verilog/display_address.sv */
`timescale 1ns/10ps

module display_address (
	input  bbc_pkg::crtc_t      crtc_i,
	input  logic [1:0]          disp_addr_offs_i,
	output bbc_pkg::disp_addr_u disp_addr_o
);

	import bbc_pkg::*;

	logic [3:0] ma_hi;
	logic [3:0] aa;

	assign ma_hi = crtc_i.ma[11:8];

	// Wrap the screen back into RAM when MA12 is set
	always_comb begin
		if (crtc_i.ma[12]) begin
			aa = ma_hi + SCROLL_OFS[disp_addr_offs_i];
		end else begin
			aa = ma_hi;
		end
	end

	always_comb begin
		disp_addr_o = '0;
		if (crtc_i.ma[13]) begin
			// Mode 7 teletext screen at 3C00 or 7C00
			disp_addr_o.ttx.aa3   = aa[3];
			disp_addr_o.ttx.ones  = 4'b1111;
			disp_addr_o.ttx.ma_lo = crtc_i.ma[9:0];
		end else begin
			// Bitmap modes, eight scan lines per character cell
			disp_addr_o.hires.aa    = aa;
			disp_addr_o.hires.ma_lo = crtc_i.ma[7:0];
			disp_addr_o.hires.ra    = crtc_i.ra[2:0];
		end
	end

endmodule

/* verilog/system_latches.sv */
`timescale 1ns/10ps

module system_latches (
	input  logic                   CLK48M_I,
	input  logic                   reset_n,
	input  bbc_pkg::cpu_bus_t      cpu_bus_i,
	input  bbc_pkg::sel_t          sel_i,
	input  logic                   model_i,
	input  logic [7:0]             sys_pb_i,
	output logic [bbc_pkg::DW-1:0] romsel_o,
	output bbc_pkg::acccon_t       acccon_o,
	output logic                   vdu_op_o,
	output logic [1:0]             disp_addr_offs_o
);

	import bbc_pkg::*;

	logic [DW-1:0] romsel;
	acccon_t       acccon;
	logic          vdu_op;
	logic [7:0]    ic32;
	logic          cpu_wr;

	// CPU write cycle, qualified by the bus clock enable
	assign cpu_wr = cpu_bus_i.clken && !cpu_bus_i.r_nw;

	// ROM select latch
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel <= '0;
		end else if (cpu_wr && sel_i.romsel) begin
			romsel <= cpu_bus_i.wdata;
			// Model B only decodes the low bits
			if (!model_i) begin
				romsel[7] <= 1'b0;
			end
		end
	end

	// Access control register, Master only
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			acccon <= '0;
		end else if (cpu_wr && sel_i.acccon && model_i) begin
			acccon <= acccon_t'(cpu_bus_i.wdata);
		end
	end

	// Remember whether the last opcode came from the VDU driver area
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			vdu_op <= 1'b0;
		end else if (cpu_bus_i.clken && cpu_bus_i.sync) begin
			vdu_op <= (cpu_bus_i.addr[15:13] == VDU_PAGE);
		end
	end

	// IC32 addressable latch, PB2..0 pick the bit and PB3 is the data
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			ic32 <= '0;
		end else begin
			ic32[sys_pb_i[2:0]] <= sys_pb_i[3];
		end
	end

	assign romsel_o         = romsel;
	assign acccon_o         = acccon;
	assign vdu_op_o         = vdu_op;
	// Screen size bits for the scroll wrap
	assign disp_addr_offs_o = ic32[5:4];

endmodule
